/* source/fir_pkg.sv */
`default_nettype none

package fir_pkg;

	localparam int unsigned SAMPLE_W = 16; // samples and coefficients, signed
	localparam int unsigned NUM_SEG = 2; // power of two only
	localparam int unsigned TAPS_PER_SEG = 4;
	localparam int unsigned NUM_TAPS = NUM_SEG * TAPS_PER_SEG;
	localparam int unsigned TAP_W = $clog2(NUM_TAPS);

	localparam int unsigned PART_W = 2 * SAMPLE_W + $clog2(TAPS_PER_SEG);
	localparam int unsigned TREE_STAGES = $clog2(NUM_SEG);
	localparam int unsigned SUM_W = PART_W + TREE_STAGES;
	localparam int unsigned Y_W = 32;

	localparam int unsigned CREDITS = 2; // granted by the consumer at reset
	localparam int unsigned CRED_W = $clog2(CREDITS + 1);

	// write port
	localparam int unsigned CFG_W = 32;
	localparam logic ADDR_COEF = 1'b0;
	localparam logic ADDR_SAMPLE = 1'b1;

	typedef union packed {
		struct packed {
			logic [CFG_W-TAP_W-SAMPLE_W-1:0] rsvd;
			logic [TAP_W-1:0] tap; // bits 18:16
			logic [SAMPLE_W-1:0] coef;
		} coef;
		struct packed {
			logic [CFG_W-SAMPLE_W-1:0] rsvd;
			logic [SAMPLE_W-1:0] sample;
		} smp;
	} cfg_word_u;

endpackage

`default_nettype wire

/* source/fir_cfg_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_cfg_decode import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic valid_strobe_i,
	input logic [SAMPLE_W-1:0] sample_i,
	input logic cfg_we_i,
	input logic cfg_addr_i,
	input logic [CFG_W-1:0] cfg_wdata_i,
	input logic credit_ok_i,
	output logic accept_o,
	output logic [SAMPLE_W-1:0] acc_sample_o,
	output logic [NUM_TAPS-1:0][SAMPLE_W-1:0] coefs_o
);

	cfg_word_u wdata;
	logic strobe_q;
	logic strobe_edge;
	logic coef_we;
	logic inject;

	assign wdata = cfg_wdata_i;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= valid_strobe_i;
		end
	end

	assign strobe_edge = valid_strobe_i && !strobe_q;
	assign coef_we = cfg_we_i && (cfg_addr_i == ADDR_COEF);
	assign inject = cfg_we_i && (cfg_addr_i == ADDR_SAMPLE);

	// a write to the sample address wins over the strobe
	assign accept_o = (inject || strobe_edge) && credit_ok_i;
	assign acc_sample_o = inject ? wdata.smp.sample : sample_i;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			coefs_o <= '0;
		end else if (coef_we) begin
			coefs_o[wdata.coef.tap] <= wdata.coef.coef;
		end
	end

endmodule

`default_nettype wire

/* source/fir_segment.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_segment import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic accept_i,
	input logic [SAMPLE_W-1:0] sample_i,
	input logic [TAPS_PER_SEG-1:0][SAMPLE_W-1:0] coefs_i,
	output logic [SAMPLE_W-1:0] shift_o,
	output logic [PART_W-1:0] part_sum_o,
	output logic part_valid_o
);

	logic [TAPS_PER_SEG-1:0][SAMPLE_W-1:0] line_q; // [0] holds the newest sample
	logic acc_q;
	logic signed [PART_W-1:0] mac;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			line_q <= '0;
		end else if (accept_i) begin
			line_q <= {line_q[TAPS_PER_SEG-2:0], sample_i};
		end
	end

	// oldest sample moves on into the next segment
	assign shift_o = line_q[TAPS_PER_SEG-1];

	always_comb begin
		mac = '0;
		for (int k = 0; k < TAPS_PER_SEG; k++) begin
			mac = mac + $signed(line_q[k]) * $signed(coefs_i[k]);
		end
	end

	// line settles one cycle after the accept, sum follows
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			acc_q <= 1'b0;
			part_valid_o <= 1'b0;
		end else begin
			acc_q <= accept_i;
			part_valid_o <= acc_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (acc_q) begin
			part_sum_o <= mac;
		end
	end

endmodule

`default_nettype wire

/* source/fir_adder_tree.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_adder_tree import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic [NUM_SEG-1:0][PART_W-1:0] part_sum_i,
	input logic [NUM_SEG-1:0] part_valid_i,
	output logic [SUM_W-1:0] sum_o,
	output logic sum_valid_o
);

	logic [SUM_W-1:0] leaf [NUM_SEG];
	logic [SUM_W-1:0] node_q [NUM_SEG-1]; // heap order, node 0 is the root
	logic [TREE_STAGES-1:0] vld_q;

	always_comb begin
		for (int i = 0; i < NUM_SEG; i++) begin
			leaf[i] = SUM_W'($signed(part_sum_i[i])); // sign extend
		end
	end

	for (genvar n = 0; n < NUM_SEG - 1; n++) begin : g_node
		if (2 * n + 1 >= NUM_SEG - 1) begin : g_bottom
			always_ff @(posedge clk_i) begin
				node_q[n] <= leaf[2*n+2-NUM_SEG] + leaf[2*n+3-NUM_SEG];
			end
		end else begin : g_inner
			always_ff @(posedge clk_i) begin
				node_q[n] <= node_q[2*n+1] + node_q[2*n+2];
			end
		end
	end

	// segments run in lockstep, so all valids rise together
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= &part_valid_i;
			for (int s = 1; s < TREE_STAGES; s++) begin
				vld_q[s] <= vld_q[s-1];
			end
		end
	end

	assign sum_o = node_q[0];
	assign sum_valid_o = vld_q[TREE_STAGES-1];

endmodule

`default_nettype wire

/* source/fir_result.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_result import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic [SUM_W-1:0] sum_i,
	input logic sum_valid_i,
	input logic accept_i,
	input logic credit_i,
	output logic credit_ok_o,
	output logic [Y_W-1:0] y_o,
	output logic y_valid_o
);

	logic [CRED_W-1:0] cnt_q; // credits still available

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			y_o <= '0;
			y_valid_o <= 1'b0;
		end else begin
			y_valid_o <= sum_valid_i;
			if (sum_valid_i) begin
				y_o <= sum_i[Y_W-1:0]; // low word only
			end
		end
	end

	// reserve on accept, release on returned credit
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q <= CRED_W'(CREDITS);
		end else begin
			case ({accept_i, credit_i})
				2'b10: cnt_q <= cnt_q - 1'b1;
				2'b01: cnt_q <= cnt_q + 1'b1;
				default: cnt_q <= cnt_q; // none or both
			endcase
		end
	end

	assign credit_ok_o = (cnt_q != '0);

endmodule

`default_nettype wire

/* source/fir_parallel.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_parallel import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic valid_strobe_i,
	input logic [SAMPLE_W-1:0] sample_i,
	input logic cfg_we_i,
	input logic cfg_addr_i,
	input logic [CFG_W-1:0] cfg_wdata_i,
	input logic credit_i,
	output logic sample_ready_o,
	output logic [Y_W-1:0] y_o,
	output logic y_valid_o
);

	logic accept;
	logic credit_ok;
	logic [NUM_TAPS-1:0][SAMPLE_W-1:0] coefs;
	logic [NUM_SEG:0][SAMPLE_W-1:0] smp_chain; // [0] from decode, last one falls off
	logic [NUM_SEG-1:0][PART_W-1:0] part_sum;
	logic [NUM_SEG-1:0] part_valid;
	logic [SUM_W-1:0] sum;
	logic sum_valid;

	assign sample_ready_o = credit_ok;

	fir_cfg_decode i_fir_cfg_decode (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.valid_strobe_i (valid_strobe_i),
		.sample_i (sample_i),
		.cfg_we_i (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.credit_ok_i (credit_ok),
		.accept_o (accept),
		.acc_sample_o (smp_chain[0]),
		.coefs_o (coefs)
	);

	for (genvar s = 0; s < NUM_SEG; s++) begin : g_seg
		fir_segment i_fir_segment (
			.clk_i (clk_i),
			.rst_ni (rst_ni),
			.accept_i (accept),
			.sample_i (smp_chain[s]),
			.coefs_i (coefs[s*TAPS_PER_SEG +: TAPS_PER_SEG]),
			.shift_o (smp_chain[s+1]),
			.part_sum_o (part_sum[s]),
			.part_valid_o (part_valid[s])
		);
	end

	fir_adder_tree i_fir_adder_tree (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.part_sum_i (part_sum),
		.part_valid_i (part_valid),
		.sum_o (sum),
		.sum_valid_o (sum_valid)
	);

	fir_result i_fir_result (
		.clk_i (clk_i),
		.rst_ni (rst_ni),
		.sum_i (sum),
		.sum_valid_i (sum_valid),
		.accept_i (accept),
		.credit_i (credit_i),
		.credit_ok_o (credit_ok),
		.y_o (y_o),
		.y_valid_o (y_valid_o)
	);

endmodule

`default_nettype wire

/* verif/fir_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_chk import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic valid_strobe_i,
	input logic cfg_we_i,
	input logic cfg_addr_i,
	input logic accept_i,
	input logic credit_i,
	input logic sample_ready_i,
	input logic y_valid_i
);

	int held; // results delivered and not yet freed by the consumer

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			held <= 0;
		end else begin
			held <= held + int'(y_valid_i) - int'(credit_i);
		end
	end

	a_accept_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		($rose(valid_strobe_i) || (cfg_we_i && cfg_addr_i)) |-> sample_ready_i)
		else $error("sample offered while sample_ready_o low");

	a_no_valid_in_reset: assert property (@(posedge clk_i)
		(!rst_ni || $past(!rst_ni)) |-> !y_valid_i)
		else $error("y_valid_o high around reset");

	// consumer must still have room for this result
	a_valid_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		y_valid_i |-> held < int'(CREDITS))
		else $error("y_valid_o without an outstanding credit");

endmodule

bind fir_parallel fir_chk i_fir_chk (
	.clk_i (clk_i),
	.rst_ni (rst_ni),
	.valid_strobe_i (valid_strobe_i),
	.cfg_we_i (cfg_we_i),
	.cfg_addr_i (cfg_addr_i),
	.accept_i (accept),
	.credit_i (credit_i),
	.sample_ready_i (sample_ready_o),
	.y_valid_i (y_valid_o)
);

`default_nettype wire

/* verif/fir_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_monitor import fir_pkg::*; (
	input logic clk_i,
	input logic rst_ni,
	input logic [Y_W-1:0] y_i,
	input logic y_valid_i,
	input logic exp_push_i,
	input logic [Y_W-1:0] exp_value_i,
	output int errors_o,
	output int pending_o
);

	logic [Y_W-1:0] exp_q[$];
	int due_q[$]; // cycle at which each result must show
	int cycle = 0;
	int err = 0;
	int pend = 0;

	assign errors_o = err;
	assign pending_o = pend;

	always @(posedge clk_i) begin
		cycle++;
	end

	// sampled mid-cycle where outputs are settled
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (y_valid_i) begin
				if (exp_q.size() == 0) begin
					$display("unexpected output on y_o at cycle %0d", cycle);
					err++;
				end else begin
					if (y_i !== exp_q[0]) begin
						$display("FAIL y_o expected %08h actual %08h", exp_q[0], y_i);
						err++;
					end
					if (cycle != due_q[0]) begin
						$display("y_valid_o came at cycle %0d instead of cycle %0d",
							cycle, due_q[0]);
						err++;
					end
					void'(exp_q.pop_front());
					void'(due_q.pop_front());
				end
			end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
				$display("no output on y_valid_o by cycle %0d", cycle);
				err++;
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
			if (exp_push_i) begin
				exp_q.push_back(exp_value_i);
				due_q.push_back(cycle + 4); // accepting edge plus 3
			end
		end
		pend = exp_q.size();
	end

endmodule

`default_nettype wire

/* verif/fir_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fir_tb import fir_pkg::*; ();

	localparam int TIMEOUT_CYC = 200;

	logic clk;
	logic rst_n;
	logic valid_strobe;
	logic [SAMPLE_W-1:0] sample;
	logic cfg_we;
	logic cfg_addr;
	logic [CFG_W-1:0] cfg_wdata;
	logic credit;
	logic sample_ready;
	logic [Y_W-1:0] y;
	logic y_valid;
	logic exp_push;
	logic [Y_W-1:0] exp_value;
	logic hold;
	logic [31:0] lfsr;
	int mon_errors;
	int mon_pending;
	int tb_errors;
	int results_seen;
	int credits_sent;

	always #5 clk = ~clk;

	fir_parallel i_fir_parallel (
		.clk_i (clk),
		.rst_ni (rst_n),
		.valid_strobe_i (valid_strobe),
		.sample_i (sample),
		.cfg_we_i (cfg_we),
		.cfg_addr_i (cfg_addr),
		.cfg_wdata_i (cfg_wdata),
		.credit_i (credit),
		.sample_ready_o (sample_ready),
		.y_o (y),
		.y_valid_o (y_valid)
	);

	fir_monitor i_fir_monitor (
		.clk_i (clk),
		.rst_ni (rst_n),
		.y_i (y),
		.y_valid_i (y_valid),
		.exp_push_i (exp_push),
		.exp_value_i (exp_value),
		.errors_o (mon_errors),
		.pending_o (mon_pending)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic idle_inputs();
		valid_strobe = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = 1'b0;
		exp_push = 1'b0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!sample_ready && n < TIMEOUT_CYC) begin
			next_cycle();
			n++;
		end
		if (!sample_ready) begin
			$display("timeout waiting for sample_ready_o");
			tb_errors++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((mon_pending != 0 || results_seen != credits_sent) && n < TIMEOUT_CYC) begin
			next_cycle();
			n++;
		end
		if (mon_pending != 0 || results_seen != credits_sent) begin
			$display("timeout waiting for outstanding results and credits");
			tb_errors++;
		end
	endtask

	task automatic expect_result(input logic [31:0] expv);
		exp_push = 1'b1;
		exp_value = expv;
	endtask

	task automatic run_op(input int op, input logic [31:0] arg, input logic [31:0] expv);
		case (op)
			0: begin // coefficient write
				cfg_we = 1'b1;
				cfg_addr = ADDR_COEF;
				cfg_wdata = arg;
				next_cycle();
				idle_inputs();
			end
			1: begin // strobe needs a low cycle after it
				wait_ready();
				sample = arg[SAMPLE_W-1:0];
				valid_strobe = 1'b1;
				expect_result(expv);
				next_cycle();
				idle_inputs();
				next_cycle();
			end
			2: begin
				wait_ready();
				cfg_we = 1'b1;
				cfg_addr = ADDR_SAMPLE;
				cfg_wdata = arg;
				expect_result(expv);
				next_cycle();
				idle_inputs();
			end
			3: repeat (arg) next_cycle();
			4: begin
				if (arg != 0) begin
					wait_drained();
				end
				hold = (arg != 0);
			end
			5: begin
				for (int i = 0; i < int'(arg); i++) begin
					if (sample_ready !== 1'b0) begin
						$display("FAIL sample_ready_o expected %h actual %h", 1'b0, sample_ready);
						tb_errors++;
					end
					next_cycle();
				end
			end
			default: begin
				$display("unknown operation %0d in pattern file", op);
				tb_errors++;
			end
		endcase
	endtask

	always @(negedge clk) begin
		if (rst_n && y_valid) begin
			results_seen++;
		end
	end

	// consumer frees each result after a random delay
	always begin : credit_return
		int delay;
		@(posedge clk);
		if (rst_n && !hold && results_seen > credits_sent) begin
			take_bits(3, delay);
			for (int i = 0; i < delay; i++) begin
				@(posedge clk);
			end
			#1;
			credit = 1'b1;
			next_cycle();
			credit = 1'b0;
			credits_sent++;
		end
	end

	initial begin
		int fd;
		int op;
		int cnt;
		logic [31:0] arg;
		logic [31:0] expv;
		string line;
		clk = 1'b0;
		rst_n = 1'b0;
		sample = '0;
		cfg_wdata = '0;
		credit = 1'b0;
		exp_value = '0;
		hold = 1'b0;
		lfsr = 32'h6c8e_7d69;
		tb_errors = 0;
		results_seen = 0;
		credits_sent = 0;
		idle_inputs();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (y_valid !== 1'b0) begin
			$display("FAIL y_valid_o expected %h actual %h", 1'b0, y_valid);
			tb_errors++;
		end
		if (sample_ready !== 1'b1) begin
			$display("FAIL sample_ready_o expected %h actual %h", 1'b1, sample_ready);
			tb_errors++;
		end
		fd = $fopen("verif/fir_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			tb_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() > 0 && line[0] != "#") begin
					cnt = $sscanf(line, "%d %h %h", op, arg, expv);
					if (cnt == 3) begin
						run_op(op, arg, expv);
					end
				end
			end
			$fclose(fd);
		end
		wait_drained();
		$display("errors: testbench %0d, monitor %0d, total %0d",
			tb_errors, mon_errors, tb_errors + mon_errors);
		if (tb_errors + mon_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/fir_pkg.sv
source/fir_cfg_decode.sv
source/fir_segment.sv
source/fir_adder_tree.sv
source/fir_result.sv
source/fir_parallel.sv
verif/fir_chk.sv
verif/fir_monitor.sv
verif/fir_tb.sv

/* run.sh */
#!/bin/sh
# build and run the FIR testbench with Verilator

verilator --binary --timing --assert -f list.f --top-module fir_tb \
	--Mdir obj_dir -o fir_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fir_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1

/* verif/fir_patterns.txt */
# op arg expected: op 0 coef write, 1 strobed sample, 2 injected sample, 3 idle cycles,
# 4 credit hold on/off, 5 expect ready low for arg cycles; arg and expected in hex
0 00000003 0
0 0001fffe 0
0 00020005 0
0 00030007 0
0 0004ffff 0
0 00050004 0
0 00060002 0
0 0007fffa 0
3 00000002 0
1 00000001 00000003
1 00000000 fffffffe
1 00000000 00000005
1 00000000 00000007
1 00000000 ffffffff
1 00000000 00000004
1 00000000 00000002
1 00000000 fffffffa
2 00000002 00000006
2 0000fffd fffffff3
2 00000064 0000013c
2 0000ffce fffffea1
1 000003e8 00000df9
1 0000fff9 fffff9e8
1 00007fff 000191c9
4 00000001 0
2 00000005 ffff1cf6
2 0000ffff 00027be7
5 00000006 0
4 00000000 0
1 00000009 00038d1a
